// File: verilog/qdq_pkg.sv
package qdq_pkg;

  // ----------------------------------------------
  // Lane and FP32 field layout
  // ----------------------------------------------

  // Width of one matrix element on every row bus
  localparam int LANE_W = 32;

  localparam int FP_MANT_W   = 23;
  localparam int FP_EXP_W    = 8;
  localparam int FP_EXP_BIAS = 127;

  // IEEE 754 single precision fields, MSB first
  typedef struct packed {
    logic                 sign;
    logic [FP_EXP_W-1:0]  exp;
    logic [FP_MANT_W-1:0] mant;
  } fp32_fields_t;

  // One lane seen either as raw bits or as FP32 fields
  typedef union packed {
    logic [LANE_W-1:0] raw;
    fp32_fields_t      f;
  } fp32_word_t;

endpackage

// File: verilog/row_if.sv
`timescale 1ns/1ps

// One matrix row per transfer, valid/ready handshake
interface row_if
  import qdq_pkg::*;
#(
  parameter int MATRIX_DIM = 4
) ();

  logic                         valid;
  logic                         ready;
  logic [MATRIX_DIM*LANE_W-1:0] data;
  // Marks row MATRIX_DIM-1 of a matrix
  logic                         last;

  modport src (
    output valid, data, last,
    input  ready
  );

  modport dst (
    input  valid, data, last,
    output ready
  );

endinterface

// File: verilog/qdq_sequencer.sv
`timescale 1ns/1ps

module qdq_sequencer
  import qdq_pkg::*;
#(
  parameter int MATRIX_DIM = 4
) (
  input  logic                         clk,
  input  logic                         rstnn,
  // Instruction queue
  input  logic                         inst_rready_i,
  output logic                         inst_rrequest_o,
  output logic                         op_finish_o,
  // Load ports
  input  logic                         a_load_valid_i,
  input  logic [MATRIX_DIM*LANE_W-1:0] a_load_data_i,
  output logic                         a_load_ready_o,
  input  logic                         acc_load_valid_i,
  input  logic [MATRIX_DIM*LANE_W-1:0] acc_load_data_i,
  output logic                         acc_load_ready_o,
  // Rows towards the converters
  row_if.src                           q_row,
  row_if.src                           dq_row,
  // Buffer status
  input  logic                         qa_full_i,
  input  logic                         qa_drain_done_i,
  input  logic                         out_full_i,
  input  logic                         out_drain_done_i
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_LOAD  = 2'd1;
  localparam logic [1:0] S_EXEC  = 2'd2;
  localparam logic [1:0] S_STORE = 2'd3;

  localparam int CNT_W = $clog2(MATRIX_DIM + 1);

  logic [1:0]       q_state;
  logic [1:0]       dq_state;
  logic [CNT_W-1:0] a_cnt;
  logic [CNT_W-1:0] acc_cnt;
  logic             start;
  logic             a_open;
  logic             acc_open;
  logic             q_done;
  logic             dq_done;

  // Both pipes step through the same sequence
  function automatic logic [1:0] next_state(input logic [1:0] cur, input logic go,
                                            input logic full, input logic done);
    logic [1:0] nxt;
    nxt = cur;
    case (cur)
      S_IDLE:  if (go) nxt = S_LOAD;
      S_LOAD:  nxt = S_EXEC;
      S_EXEC:  if (full) nxt = S_STORE;
      default: if (done) nxt = S_IDLE;
    endcase
    return nxt;
  endfunction

  // ----------------------------------------------
  // Pipe FSMs
  // ----------------------------------------------
  assign start = (q_state == S_IDLE) && (dq_state == S_IDLE) && inst_rready_i;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      q_state  <= S_IDLE;
      dq_state <= S_IDLE;
    end else begin
      q_state  <= next_state(q_state, start, qa_full_i, qa_drain_done_i);
      dq_state <= next_state(dq_state, start, out_full_i, out_drain_done_i);
    end
  end

  // ----------------------------------------------
  // Load row counting
  // ----------------------------------------------
  assign a_open   = (q_state == S_EXEC) && (a_cnt < CNT_W'(MATRIX_DIM));
  assign acc_open = (dq_state == S_EXEC) && (acc_cnt < CNT_W'(MATRIX_DIM));

  assign a_load_ready_o   = a_open && q_row.ready;
  assign acc_load_ready_o = acc_open && dq_row.ready;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      a_cnt   <= '0;
      acc_cnt <= '0;
    end else begin
      if (q_state == S_LOAD) a_cnt <= '0;
      else if (a_load_valid_i && a_load_ready_o) a_cnt <= a_cnt + 1'b1;
      if (dq_state == S_LOAD) acc_cnt <= '0;
      else if (acc_load_valid_i && acc_load_ready_o) acc_cnt <= acc_cnt + 1'b1;
    end
  end

  // Forward load rows, last taken from the count
  assign q_row.valid  = a_open && a_load_valid_i;
  assign q_row.data   = a_load_data_i;
  assign q_row.last   = (a_cnt == CNT_W'(MATRIX_DIM - 1));
  assign dq_row.valid = acc_open && acc_load_valid_i;
  assign dq_row.data  = acc_load_data_i;
  assign dq_row.last  = (acc_cnt == CNT_W'(MATRIX_DIM - 1));

  // ----------------------------------------------
  // Instruction pop and finish
  // ----------------------------------------------
  assign q_done  = (q_state == S_STORE) && qa_drain_done_i;
  assign dq_done = (dq_state == S_STORE) && out_drain_done_i;

  // Pop once, when the later of the two pipes leaves store
  assign inst_rrequest_o = (q_done && (dq_done || dq_state == S_IDLE)) ||
                           (dq_done && q_state == S_IDLE);
  assign op_finish_o     = (q_state == S_IDLE) && (dq_state == S_IDLE);

  // Drain done only counts while the pipe waits in store
  a_qa_drain_in_store: assert property (@(posedge clk) disable iff (!rstnn)
    qa_drain_done_i |-> q_state == S_STORE);

  a_out_drain_in_store: assert property (@(posedge clk) disable iff (!rstnn)
    out_drain_done_i |-> dq_state == S_STORE);

endmodule

// File: verilog/row_quantizer.sv
`timescale 1ns/1ps

module row_quantizer
  import qdq_pkg::*;
#(
  parameter int MATRIX_DIM  = 4,
  parameter int QUANT_SHIFT = 4
) (
  input  logic clk,
  input  logic rstnn,
  row_if.dst   in_row,
  row_if.src   out_row
);

  localparam int ROW_W = MATRIX_DIM * LANE_W;
  localparam int Q_W   = 8;

  logic [ROW_W-1:0] conv;
  logic [ROW_W-1:0] out_data;
  logic             out_last;
  logic             out_valid;

  // FP32 times 2^QUANT_SHIFT, truncated, saturated to +-127
  function automatic logic [LANE_W-1:0] quant_lane(input logic [LANE_W-1:0] bits);
    fp32_word_t       w;
    int               e;
    logic [FP_MANT_W:0] sig;
    logic [Q_W-1:0]   mag;
    logic [Q_W-1:0]   q;
    w.raw = bits;
    e     = int'(w.f.exp) - FP_EXP_BIAS + QUANT_SHIFT;
    sig   = {1'b1, w.f.mant};
    if (w.f.exp == '0) mag = '0;
    // Inf and NaN saturate by sign
    else if (w.f.exp == '1) mag = Q_W'(127);
    else if (e < 0) mag = '0;
    else if (e >= Q_W - 1) mag = Q_W'(127);
    else mag = Q_W'(sig >> (FP_MANT_W - e));
    q = w.f.sign ? (~mag + 1'b1) : mag;
    return {{(LANE_W - Q_W){q[Q_W-1]}}, q};
  endfunction

  always_comb begin
    for (int l = 0; l < MATRIX_DIM; l++) begin
      conv[l*LANE_W +: LANE_W] = quant_lane(in_row.data[l*LANE_W +: LANE_W]);
    end
  end

  // Single output register, refilled as it is taken
  assign in_row.ready = !out_valid || out_row.ready;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      out_valid <= 1'b0;
    end else if (in_row.valid && in_row.ready) begin
      out_valid <= 1'b1;
    end else if (out_row.ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_row.valid && in_row.ready) begin
      out_data <= conv;
      out_last <= in_row.last;
    end
  end

  assign out_row.valid = out_valid;
  assign out_row.data  = out_data;
  assign out_row.last  = out_last;

  // Sender holds a refused row
  a_in_stable: assert property (@(posedge clk) disable iff (!rstnn)
    in_row.valid && !in_row.ready |=>
      in_row.valid && $stable(in_row.data) && $stable(in_row.last));

endmodule

// File: verilog/row_dequantizer.sv
`timescale 1ns/1ps

module row_dequantizer
  import qdq_pkg::*;
#(
  parameter int MATRIX_DIM    = 4,
  parameter int DEQUANT_SHIFT = 8
) (
  input  logic clk,
  input  logic rstnn,
  row_if.dst   in_row,
  row_if.src   out_row
);

  localparam int ROW_W = MATRIX_DIM * LANE_W;

  logic [ROW_W-1:0] conv;
  logic [ROW_W-1:0] out_data;
  logic             out_last;
  logic             out_valid;

  // Signed int32 times 2^-DEQUANT_SHIFT as FP32, mantissa truncated
  function automatic logic [LANE_W-1:0] dequant_lane(input logic [LANE_W-1:0] acc);
    fp32_word_t        w;
    logic [LANE_W-1:0] mag;
    logic [LANE_W-1:0] norm;
    int                msb;
    int                bexp;
    w.raw = '0;
    mag   = acc[LANE_W-1] ? (~acc + 1'b1) : acc;
    msb   = 0;
    for (int i = 0; i < LANE_W; i++) begin
      if (mag[i]) msb = i;
    end
    // Leading one moves to the top bit, dropped as the hidden bit
    norm = mag << (LANE_W - 1 - msb);
    bexp = msb - DEQUANT_SHIFT + FP_EXP_BIAS;
    if (mag != '0) begin
      w.f.sign = acc[LANE_W-1];
      if (bexp > 0) begin
        w.f.exp  = FP_EXP_W'(bexp);
        w.f.mant = norm[LANE_W-2 -: FP_MANT_W];
      end
    end
    return w.raw;
  endfunction

  always_comb begin
    for (int l = 0; l < MATRIX_DIM; l++) begin
      conv[l*LANE_W +: LANE_W] = dequant_lane(in_row.data[l*LANE_W +: LANE_W]);
    end
  end

  assign in_row.ready = !out_valid || out_row.ready;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      out_valid <= 1'b0;
    end else if (in_row.valid && in_row.ready) begin
      out_valid <= 1'b1;
    end else if (out_row.ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_row.valid && in_row.ready) begin
      out_data <= conv;
      out_last <= in_row.last;
    end
  end

  assign out_row.valid = out_valid;
  assign out_row.data  = out_data;
  assign out_row.last  = out_last;

  // Sender holds a refused row
  a_in_stable: assert property (@(posedge clk) disable iff (!rstnn)
    in_row.valid && !in_row.ready |=>
      in_row.valid && $stable(in_row.data) && $stable(in_row.last));

endmodule

// File: verilog/matrix_row_buffer.sv
`timescale 1ns/1ps

module matrix_row_buffer
  import qdq_pkg::*;
#(
  parameter int MATRIX_DIM = 4
) (
  input  logic                         clk,
  input  logic                         rstnn,
  row_if.dst                           wr_row,
  // Store port
  output logic                         store_valid_o,
  output logic [MATRIX_DIM*LANE_W-1:0] store_data_o,
  input  logic                         store_ready_i,
  // Status towards the sequencer
  output logic                         full_o,
  output logic                         drain_done_o
);

  localparam int ROW_W = MATRIX_DIM * LANE_W;
  localparam int IDX_W = (MATRIX_DIM > 1) ? $clog2(MATRIX_DIM) : 1;

  logic [ROW_W-1:0] mem [MATRIX_DIM];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             full;
  logic             drain_done;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_row.ready = !full;
  assign wr_fire      = wr_row.valid && !full;
  assign rd_fire      = full && store_ready_i;

  // ----------------------------------------------
  // Fill side
  // ----------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_idx] <= wr_row.data;
    end
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      wr_idx <= '0;
    end else if (wr_fire) begin
      // Next matrix starts again at row 0
      wr_idx <= wr_row.last ? '0 : wr_idx + 1'b1;
    end
  end

  // ----------------------------------------------
  // Drain side
  // ----------------------------------------------
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      full       <= 1'b0;
      rd_idx     <= '0;
      drain_done <= 1'b0;
    end else begin
      drain_done <= 1'b0;
      if (wr_fire && wr_row.last) begin
        full <= 1'b1;
      end
      if (rd_fire) begin
        if (rd_idx == IDX_W'(MATRIX_DIM - 1)) begin
          full       <= 1'b0;
          rd_idx     <= '0;
          drain_done <= 1'b1;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  assign store_valid_o = full;
  assign store_data_o  = mem[rd_idx];
  assign full_o        = full;
  assign drain_done_o  = drain_done;

  // Upstream stops before the buffer fills, so nothing waits on a full buffer
  a_no_write_when_full: assert property (@(posedge clk) disable iff (!rstnn)
    wr_row.valid |-> !full_o);

endmodule

// File: verilog/qdq_matrix_top.sv
`timescale 1ns/1ps

module qdq_matrix_top
  import qdq_pkg::*;
#(
  parameter int MATRIX_DIM    = 4,
  parameter int QUANT_SHIFT   = 4,
  parameter int DEQUANT_SHIFT = 8
) (
  input  logic                         clk,
  input  logic                         rstnn,
  // Instruction
  input  logic                         inst_rready_i,
  output logic                         inst_rrequest_o,
  output logic                         op_finish_o,
  // FP32 matrix A rows
  input  logic                         a_load_valid_i,
  input  logic [MATRIX_DIM*LANE_W-1:0] a_load_data_i,
  output logic                         a_load_ready_o,
  // int32 accumulator rows
  input  logic                         acc_load_valid_i,
  input  logic [MATRIX_DIM*LANE_W-1:0] acc_load_data_i,
  output logic                         acc_load_ready_o,
  // Quantized A rows
  output logic                         qa_store_valid_o,
  output logic [MATRIX_DIM*LANE_W-1:0] qa_store_data_o,
  input  logic                         qa_store_ready_i,
  // Dequantized FP32 rows
  output logic                         out_store_valid_o,
  output logic [MATRIX_DIM*LANE_W-1:0] out_store_data_o,
  input  logic                         out_store_ready_i
);

  logic qa_full;
  logic qa_drain_done;
  logic out_full;
  logic out_drain_done;

  row_if #(.MATRIX_DIM(MATRIX_DIM)) q_in_row ();
  row_if #(.MATRIX_DIM(MATRIX_DIM)) q_out_row ();
  row_if #(.MATRIX_DIM(MATRIX_DIM)) dq_in_row ();
  row_if #(.MATRIX_DIM(MATRIX_DIM)) dq_out_row ();

  qdq_sequencer #(
    .MATRIX_DIM (MATRIX_DIM)
  ) u_sequencer (
    .clk              (clk),
    .rstnn            (rstnn),
    .inst_rready_i    (inst_rready_i),
    .inst_rrequest_o  (inst_rrequest_o),
    .op_finish_o      (op_finish_o),
    .a_load_valid_i   (a_load_valid_i),
    .a_load_data_i    (a_load_data_i),
    .a_load_ready_o   (a_load_ready_o),
    .acc_load_valid_i (acc_load_valid_i),
    .acc_load_data_i  (acc_load_data_i),
    .acc_load_ready_o (acc_load_ready_o),
    .q_row            (q_in_row),
    .dq_row           (dq_in_row),
    .qa_full_i        (qa_full),
    .qa_drain_done_i  (qa_drain_done),
    .out_full_i       (out_full),
    .out_drain_done_i (out_drain_done)
  );

  // ----------------------------------------------
  // Quant pipe
  // ----------------------------------------------
  row_quantizer #(
    .MATRIX_DIM  (MATRIX_DIM),
    .QUANT_SHIFT (QUANT_SHIFT)
  ) u_quantizer (
    .clk     (clk),
    .rstnn   (rstnn),
    .in_row  (q_in_row),
    .out_row (q_out_row)
  );

  matrix_row_buffer #(
    .MATRIX_DIM (MATRIX_DIM)
  ) u_qa_buf (
    .clk           (clk),
    .rstnn         (rstnn),
    .wr_row        (q_out_row),
    .store_valid_o (qa_store_valid_o),
    .store_data_o  (qa_store_data_o),
    .store_ready_i (qa_store_ready_i),
    .full_o        (qa_full),
    .drain_done_o  (qa_drain_done)
  );

  // ----------------------------------------------
  // Dequant pipe
  // ----------------------------------------------
  row_dequantizer #(
    .MATRIX_DIM    (MATRIX_DIM),
    .DEQUANT_SHIFT (DEQUANT_SHIFT)
  ) u_dequantizer (
    .clk     (clk),
    .rstnn   (rstnn),
    .in_row  (dq_in_row),
    .out_row (dq_out_row)
  );

  matrix_row_buffer #(
    .MATRIX_DIM (MATRIX_DIM)
  ) u_out_buf (
    .clk           (clk),
    .rstnn         (rstnn),
    .wr_row        (dq_out_row),
    .store_valid_o (out_store_valid_o),
    .store_data_o  (out_store_data_o),
    .store_ready_i (out_store_ready_i),
    .full_o        (out_full),
    .drain_done_o  (out_drain_done)
  );

endmodule

// File: dv/tb_qdq_matrix.sv
`timescale 1ns/1ps

module tb_qdq_matrix
  import qdq_pkg::*;
();

  localparam int DIM             = 4;
  localparam int Q_SHIFT         = 4;
  localparam int DQ_SHIFT        = 8;
  localparam int ROW_W           = DIM * LANE_W;
  localparam int N_ENT           = 4;
  localparam int WATCHDOG_CYCLES = N_ENT * DIM * 200 + 10;

  logic             clk = 1'b0;
  logic             rstnn;
  logic             inst_rready_i;
  logic             inst_rrequest_o;
  logic             op_finish_o;
  logic             a_load_valid_i;
  logic [ROW_W-1:0] a_load_data_i;
  logic             a_load_ready_o;
  logic             acc_load_valid_i;
  logic [ROW_W-1:0] acc_load_data_i;
  logic             acc_load_ready_o;
  logic             qa_store_valid_o;
  logic [ROW_W-1:0] qa_store_data_o;
  logic             qa_store_ready_i;
  logic             out_store_valid_o;
  logic [ROW_W-1:0] out_store_data_o;
  logic             out_store_ready_i;

  // Stimulus rows, expected rows and stall density per entry
  logic [ROW_W-1:0] a_tab   [N_ENT][DIM];
  logic [ROW_W-1:0] acc_tab [N_ENT][DIM];
  logic [ROW_W-1:0] qa_exp  [N_ENT][DIM];
  logic [ROW_W-1:0] out_exp [N_ENT][DIM];
  logic [1:0]       load_stall  [N_ENT];
  logic [1:0]       store_stall [N_ENT];
  // Keep the instruction level high into the next entry
  logic             hold_inst   [N_ENT];
  logic [31:0]      rng_state;

  always #10 clk = ~clk;

  qdq_matrix_top #(
    .MATRIX_DIM    (DIM),
    .QUANT_SHIFT   (Q_SHIFT),
    .DEQUANT_SHIFT (DQ_SHIFT)
  ) u_qdq_matrix_top (
    .clk               (clk),
    .rstnn             (rstnn),
    .inst_rready_i     (inst_rready_i),
    .inst_rrequest_o   (inst_rrequest_o),
    .op_finish_o       (op_finish_o),
    .a_load_valid_i    (a_load_valid_i),
    .a_load_data_i     (a_load_data_i),
    .a_load_ready_o    (a_load_ready_o),
    .acc_load_valid_i  (acc_load_valid_i),
    .acc_load_data_i   (acc_load_data_i),
    .acc_load_ready_o  (acc_load_ready_o),
    .qa_store_valid_o  (qa_store_valid_o),
    .qa_store_data_o   (qa_store_data_o),
    .qa_store_ready_i  (qa_store_ready_i),
    .out_store_valid_o (out_store_valid_o),
    .out_store_data_o  (out_store_data_o),
    .out_store_ready_i (out_store_ready_i)
  );

  // ----------------------------------------------
  // Random numbers and reference model
  // ----------------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic real pow2(input int n);
    real p;
    p = 1.0;
    for (int i = 0; i < n; i++) p = p * 2.0;
    for (int i = 0; i > n; i--) p = p / 2.0;
    return p;
  endfunction

  // FP32 value scaled, clamped in real, then truncated toward zero
  function automatic logic [LANE_W-1:0] quant_ref(input logic [31:0] bits);
    int  exp_f;
    int  mant_i;
    real val;
    int  q;
    exp_f  = int'(bits[30:23]);
    mant_i = int'(bits[22:0]);
    if (exp_f == 255) begin
      q = bits[31] ? -127 : 127;
    end else begin
      if (exp_f == 0) val = $itor(mant_i) / pow2(23) * pow2(-126);
      else val = (1.0 + $itor(mant_i) / pow2(23)) * pow2(exp_f - 127);
      if (bits[31]) val = -val;
      val = val * pow2(Q_SHIFT);
      if (val > 127.0) val = 127.0;
      if (val < -127.0) val = -127.0;
      q = $rtoi(val);
    end
    return LANE_W'(q);
  endfunction

  // Exact in double for magnitudes below 2^24, narrowed to FP32 fields
  function automatic logic [LANE_W-1:0] dequant_ref(input logic [31:0] acc);
    real         val;
    logic [63:0] dbits;
    logic [7:0]  fexp;
    if (acc == 0) return '0;
    val   = $itor($signed(acc)) / pow2(DQ_SHIFT);
    dbits = $realtobits(val);
    fexp  = 8'(int'(dbits[62:52]) - 1023 + FP_EXP_BIAS);
    return {dbits[63], fexp, dbits[51:29]};
  endfunction

  task automatic build_table();
    logic [31:0] rnd;
    logic [31:0] mag;
    // Entry 0 corner values, lane 0 in the low word
    a_tab[0][0]   = {32'h0000_0000, 32'h3e99_999a, 32'hc020_0000, 32'h3f80_0000};
    a_tab[0][1]   = {32'hff80_0000, 32'h7f80_0000, 32'hc2c8_0000, 32'h42c8_0000};
    a_tab[0][2]   = {32'h40fe_0000, 32'h0000_0001, 32'h8000_0000, 32'h7fc0_0000};
    a_tab[0][3]   = {32'hc0fe_0000, 32'h4100_0000, 32'hbd4c_cccd, 32'h3d80_0000};
    acc_tab[0][0] = {32'd0, -32'sd512, 32'd256, 32'd1};
    acc_tab[0][1] = {32'd100, -32'sd16777215, 32'd8388607, -32'sd1};
    acc_tab[0][2] = {-32'sd12345, 32'd12345, 32'd65536, -32'sd3};
    acc_tab[0][3] = {32'd16777215, -32'sd256, 32'd0, 32'd7};
    for (int e = 1; e < N_ENT; e++) begin
      for (int r = 0; r < DIM; r++) begin
        for (int l = 0; l < DIM; l++) begin
          rnd = next_rand();
          // Exponents 117..132 cover zero results up to saturation
          a_tab[e][r][l*LANE_W +: LANE_W] = {rnd[31], 8'(117 + rnd[27:24]), rnd[22:0]};
          rnd = next_rand();
          mag = {8'd0, rnd[23:0]};
          if (rnd[31:29] == 3'd0) mag = '0;
          acc_tab[e][r][l*LANE_W +: LANE_W] = rnd[30] ? (~mag + 1'b1) : mag;
        end
      end
    end
    for (int e = 0; e < N_ENT; e++) begin
      for (int r = 0; r < DIM; r++) begin
        for (int l = 0; l < DIM; l++) begin
          qa_exp[e][r][l*LANE_W +: LANE_W]  = quant_ref(a_tab[e][r][l*LANE_W +: LANE_W]);
          out_exp[e][r][l*LANE_W +: LANE_W] = dequant_ref(acc_tab[e][r][l*LANE_W +: LANE_W]);
        end
      end
    end
    load_stall  = '{2'd0, 2'd1, 2'd2, 2'd1};
    store_stall = '{2'd0, 2'd2, 2'd1, 2'd3};
    hold_inst   = '{1'b0, 1'b1, 1'b1, 1'b0};
  endtask

  // ----------------------------------------------
  // Checks and stimulus
  // ----------------------------------------------
  task automatic check_value(input string name, input logic [ROW_W-1:0] expected,
                             input logic [ROW_W-1:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic run_entry(input int e);
    int          a_idx;
    int          acc_idx;
    int          qa_got;
    int          out_got;
    int          pops;
    bit          a_fire;
    bit          acc_fire;
    logic [31:0] rnd;
    a_idx    = 0;
    acc_idx  = 0;
    qa_got   = 0;
    out_got  = 0;
    pops     = 0;
    a_fire   = 1'b0;
    acc_fire = 1'b0;
    @(negedge clk);
    inst_rready_i = 1'b1;
    #1;
    check_value("op_finish_o before start", ROW_W'(1), ROW_W'(op_finish_o));
    check_value("inst_rrequest_o before start", ROW_W'(0), ROW_W'(inst_rrequest_o));
    while (pops == 0) begin
      @(negedge clk);
      if (a_fire) begin
        a_idx++;
        a_load_valid_i = 1'b0;
      end
      if (acc_fire) begin
        acc_idx++;
        acc_load_valid_i = 1'b0;
      end
      // A row once offered is held until taken
      rnd = next_rand();
      if (!a_load_valid_i && a_idx < DIM && rnd[1:0] >= load_stall[e]) begin
        a_load_valid_i = 1'b1;
        a_load_data_i  = a_tab[e][a_idx];
      end
      if (!acc_load_valid_i && acc_idx < DIM && rnd[5:4] >= load_stall[e]) begin
        acc_load_valid_i = 1'b1;
        acc_load_data_i  = acc_tab[e][acc_idx];
      end
      rnd = next_rand();
      qa_store_ready_i  = (rnd[1:0] >= store_stall[e]);
      out_store_ready_i = (rnd[5:4] >= store_stall[e]);
      #1;
      check_value("op_finish_o while busy", ROW_W'(0), ROW_W'(op_finish_o));
      a_fire   = a_load_valid_i && a_load_ready_o;
      acc_fire = acc_load_valid_i && acc_load_ready_o;
      if (a_idx >= DIM) check_value("a_load_ready_o", ROW_W'(0), ROW_W'(a_load_ready_o));
      if (acc_idx >= DIM) check_value("acc_load_ready_o", ROW_W'(0), ROW_W'(acc_load_ready_o));
      if (qa_store_valid_o && qa_store_ready_i) begin
        if (qa_got >= DIM) check_value("qa store row count", ROW_W'(DIM), ROW_W'(qa_got + 1));
        check_value($sformatf("qa_store_data_o row %0d", qa_got), qa_exp[e][qa_got],
                    qa_store_data_o);
        qa_got++;
      end
      if (out_store_valid_o && out_store_ready_i) begin
        if (out_got >= DIM) check_value("out store row count", ROW_W'(DIM), ROW_W'(out_got + 1));
        check_value($sformatf("out_store_data_o row %0d", out_got), out_exp[e][out_got],
                    out_store_data_o);
        out_got++;
      end
      if (inst_rrequest_o) begin
        // Pop only once both stores are complete
        check_value("qa store row count", ROW_W'(DIM), ROW_W'(qa_got));
        check_value("out store row count", ROW_W'(DIM), ROW_W'(out_got));
        pops++;
      end
    end
    if (!hold_inst[e]) begin
      @(negedge clk);
      inst_rready_i = 1'b0;
      #1;
      check_value("inst_rrequest_o after pop", ROW_W'(0), ROW_W'(inst_rrequest_o));
      check_value("op_finish_o after pop", ROW_W'(1), ROW_W'(op_finish_o));
    end
  endtask

  initial begin
    rstnn             = 1'b0;
    inst_rready_i     = 1'b0;
    a_load_valid_i    = 1'b0;
    a_load_data_i     = '0;
    acc_load_valid_i  = 1'b0;
    acc_load_data_i   = '0;
    qa_store_ready_i  = 1'b0;
    out_store_ready_i = 1'b0;
    rng_state         = 32'h51fc7670;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstnn = 1'b1;
    #1;
    check_value("op_finish_o after reset", ROW_W'(1), ROW_W'(op_finish_o));
    check_value("inst_rrequest_o after reset", ROW_W'(0), ROW_W'(inst_rrequest_o));
    check_value("qa_store_valid_o after reset", ROW_W'(0), ROW_W'(qa_store_valid_o));
    check_value("out_store_valid_o after reset", ROW_W'(0), ROW_W'(out_store_valid_o));
    check_value("a_load_ready_o after reset", ROW_W'(0), ROW_W'(a_load_ready_o));
    check_value("acc_load_ready_o after reset", ROW_W'(0), ROW_W'(acc_load_ready_o));
    for (int e = 0; e < N_ENT; e++) begin
      run_entry(e);
    end
    $display("Done: no errors");
    $finish;
  end

  // Bound on the whole run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the instruction table did not finish within %0d cycles",
             WATCHDOG_CYCLES);
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: list.f
verilog/qdq_pkg.sv
verilog/row_if.sv
verilog/qdq_sequencer.sv
verilog/row_quantizer.sv
verilog/row_dequantizer.sv
verilog/matrix_row_buffer.sv
verilog/qdq_matrix_top.sv
dv/tb_qdq_matrix.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_qdq_matrix
FILE_LIST   ?= list.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert -j 0
PASS_STRING ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STRING)"

clean:
	rm -rf $(OBJ_DIR)
